// File: src.f
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/exec_if.sv
hw/regfile.sv
hw/issue_decode.sv
hw/int_alu.sv
hw/mul_unit.sv
hw/result_merge.sv
hw/rv_exec_core.sv
testbench/rv_exec_core_assertions.sv
testbench/tb_rv_exec_core.sv

// File: Bender.yml
package:
  name: rv_exec_core

sources:
  - hw/rv_isa_pkg.sv
  - hw/core_pkg.sv
  - hw/exec_if.sv
  - hw/regfile.sv
  - hw/issue_decode.sv
  - hw/int_alu.sv
  - hw/mul_unit.sv
  - hw/result_merge.sv
  - hw/rv_exec_core.sv
  - target: simulation
    files:
      - testbench/rv_exec_core_assertions.sv
      - testbench/tb_rv_exec_core.sv

// File: testbench/tb_rv_exec_core.sv
`timescale 1ns/1ns

module tb_rv_exec_core;
  import rv_isa_pkg::*;

  logic clk;
  logic rst_n;
  logic instr_valid;
  logic [31:0] instr;
  logic wb_valid;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0] wb_data;

  // reference state, updated at issue in program order
  logic [31:0] ref_regs [32];
  logic [36:0] exp_q [$];
  string test_name;
  int err_count;
  int errs_at_start;
  int tests_passed;
  int tests_failed;
  int wb_count;
  int exp_count;

  rv_exec_core dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, op_imm};
  endfunction

  function automatic logic [31:0] alu_rule(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] mul_rule(input logic [2:0] f3, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] p;
    // mulh and mulhsu take rs1 as signed, only mulh takes rs2 as signed
    ax = ((f3 == 3'd1) || (f3 == 3'd2)) ? {{32{a[31]}}, a} : {32'd0, a};
    bx = (f3 == 3'd1) ? {{32{b[31]}}, b} : {32'd0, b};
    p = ax * bx;
    return (f3 == 3'd0) ? p[31:0] : p[63:32];
  endfunction

  function automatic void model_instr(input logic [31:0] ins);
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic legal;
    f7 = ins[31:25];
    f3 = ins[14:12];
    rd = ins[11:7];
    a = ref_regs[ins[19:15]];
    legal = 1'b0;
    res = '0;
    if (ins[6:0] == op_reg) begin
      b = ref_regs[ins[24:20]];
      if (f7 == funct7_base) begin
        legal = 1'b1;
        res = alu_rule(f3, 1'b0, a, b);
      end else if (f7 == funct7_alt) begin
        legal = (f3 == 3'd0) || (f3 == 3'd5);
        res = alu_rule(f3, 1'b1, a, b);
      end else if (f7 == funct7_muldiv) begin
        legal = !f3[2];
        res = mul_rule(f3, a, b);
      end
    end else if (ins[6:0] == op_imm) begin
      b = {{20{ins[31]}}, ins[31:20]};
      legal = ((f3 != 3'd1) && (f3 != 3'd5)) || (f7 == funct7_base) ||
              ((f3 == 3'd5) && (f7 == funct7_alt));
      res = alu_rule(f3, (f3 == 3'd5) && (f7 == funct7_alt), a, b);
    end
    if (legal && (rd != 5'd0)) begin
      ref_regs[rd] = res;
      exp_q.push_back({rd, res});
      exp_count++;
    end
  endfunction

  function automatic logic [31:0] random_instr();
    logic [31:0] ins;
    int sel;
    ins = $urandom();
    sel = $urandom_range(9);
    if (sel >= 5) begin
      ins[6:0] = op_reg;
      if (sel == 5) begin
        ins[31:25] = funct7_alt;
      end else if (sel == 6) begin
        ins[31:25] = funct7_muldiv;
      end else begin
        ins[31:25] = funct7_base;
      end
    end else if (sel >= 1) begin
      ins[6:0] = op_imm;
      if (ins[13:12] == 2'b01) begin
        ins[31:25] = ins[26] ? funct7_alt : funct7_base;
      end
    end
    // small register window keeps dependencies frequent
    if ($urandom_range(3) != 0) begin
      ins[11:7] = 5'($urandom_range(7));
      ins[19:15] = 5'($urandom_range(7));
      if (ins[6:0] == op_reg) begin
        ins[24:20] = 5'($urandom_range(7));
      end
    end
    return ins;
  endfunction

  function automatic int total_errors();
    return err_count + dut0.chk0.fail_count;
  endfunction

  // compare each retired result with the oldest expected one
  always @(negedge clk) begin : wb_monitor
    logic [36:0] expected;
    if (rst_n && wb_valid) begin
      wb_count++;
      assert (exp_q.size() != 0) else begin
        $display("%s: x%0d retired but no instruction was expected to", test_name, wb_rd);
        err_count++;
      end
      if (exp_q.size() != 0) begin
        expected = exp_q.pop_front();
        assert (wb_rd == expected[36:32]) else begin
          $display("ERROR %s: wb_rd expected %0d actual %0d", test_name,
                   expected[36:32], wb_rd);
          err_count++;
        end
        assert (wb_data == expected[31:0]) else begin
          $display("ERROR %s: wb_data expected 0x%08h actual 0x%08h", test_name,
                   expected[31:0], wb_data);
          err_count++;
        end
      end
    end
  end

  task automatic issue(input logic [31:0] ins);
    @(negedge clk);
    instr_valid = 1'b1;
    instr = ins;
    model_instr(ins);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      instr_valid = 1'b0;
    end
  endtask

  // shift in 11 + 11 + 10 bits with immediates that stay positive
  task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
    issue(i_type({1'b0, v[31:21]}, f3_add_sub, r, 5'd0));
    issue(i_type(12'd11, f3_sll, r, r));
    issue(i_type({1'b0, v[20:10]}, f3_or, r, r));
    issue(i_type(12'd10, f3_sll, r, r));
    issue(i_type({2'b0, v[9:0]}, f3_or, r, r));
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errs_at_start = total_errors();
    wb_count = 0;
    exp_count = 0;
  endtask

  task automatic finish_test();
    int cycles;
    idle(1);
    cycles = 0;
    while ((exp_q.size() != 0) && (cycles < 20)) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: timed out waiting for %0d results to retire", test_name, exp_q.size());
      err_count++;
      exp_q.delete();
    end
    // a late or spurious writeback would show up here
    idle(3);
    assert (wb_count == exp_count) else begin
      $display("ERROR %s: retire count expected %0d actual %0d", test_name,
               exp_count, wb_count);
      err_count++;
    end
    if (total_errors() == errs_at_start) begin
      tests_passed++;
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED", test_name);
    end
  endtask

  initial begin : main
    logic [11:0] imm;
    void'($urandom(57));
    rst_n = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    err_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    foreach (ref_regs[i]) begin
      ref_regs[i] = '0;
    end
    #1 rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    idle(2);

    start_test("reg_reg_alu");
    repeat (3) begin
      load_reg(5'd1, $urandom());
      load_reg(5'd2, $urandom());
      for (int f = 0; f < 8; f++) begin
        issue(r_type(funct7_base, f[2:0], 5'(f + 5), 5'd1, 5'd2));
      end
      issue(r_type(funct7_alt, f3_add_sub, 5'd13, 5'd1, 5'd2));
      issue(r_type(funct7_alt, f3_srl_sra, 5'd14, 5'd1, 5'd2));
      idle(1);
    end
    finish_test();

    start_test("reg_imm_alu");
    load_reg(5'd3, $urandom());
    for (int n = 0; n < 32; n++) begin
      imm = 12'($urandom());
      imm[11] = n[3];
      if (n[2:0] == f3_sll) begin
        imm[11:5] = funct7_base;
      end else if (n[2:0] == f3_srl_sra) begin
        imm[11:5] = n[3] ? funct7_alt : funct7_base;
      end
      issue(i_type(imm, n[2:0], 5'(n[3:0] + 8), 5'd3));
    end
    finish_test();

    start_test("multiply");
    load_reg(5'd1, 32'h8000_0000);
    load_reg(5'd2, 32'hffff_ffff);
    load_reg(5'd3, 32'h7fff_ffff);
    load_reg(5'd4, $urandom() | 32'h8000_0000);
    load_reg(5'd5, $urandom());
    for (int s = 1; s <= 5; s++) begin
      for (int t = 1; t <= 5; t++) begin
        for (int f = 0; f < 4; f++) begin
          issue(r_type(funct7_muldiv, f[2:0], 5'(f + 8), 5'(s), 5'(t)));
        end
      end
    end
    finish_test();

    start_test("back_to_back");
    load_reg(5'd5, $urandom());
    for (int n = 0; n < 12; n++) begin
      issue(i_type(12'($urandom()), f3_add_sub, 5'd5, 5'd5));
      issue(r_type(funct7_base, f3_xor, 5'd6, 5'd5, 5'd6));
      // x6 one slot back, x5 two slots back
      issue(r_type(funct7_muldiv, f3_mul, 5'd7, 5'd6, 5'd5));
      issue(r_type(funct7_base, f3_add_sub, 5'd8, 5'd7, 5'd7));
    end
    finish_test();

    start_test("x0_and_illegal");
    load_reg(5'd1, $urandom());
    issue(i_type(12'h123, f3_add_sub, 5'd0, 5'd1));
    issue(r_type(funct7_base, f3_add_sub, 5'd0, 5'd1, 5'd1));
    issue({25'h1abcd, 7'b1111111});
    issue(r_type(7'h7f, f3_add_sub, 5'd9, 5'd1, 5'd1));
    issue(r_type(funct7_alt, f3_xor, 5'd9, 5'd1, 5'd1));
    issue(r_type(funct7_muldiv, 3'd4, 5'd9, 5'd1, 5'd1));
    issue(i_type(12'h401, f3_sll, 5'd9, 5'd1));
    issue(r_type(funct7_base, f3_add_sub, 5'd10, 5'd0, 5'd1));
    issue(r_type(funct7_base, f3_or, 5'd11, 5'd1, 5'd0));
    issue(r_type(funct7_muldiv, f3_mul, 5'd12, 5'd0, 5'd1));
    finish_test();

    start_test("random_stream");
    for (int n = 0; n < 300; n++) begin
      issue(random_instr());
      idle($urandom_range(2));
    end
    finish_test();

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if ((tests_failed == 0) && (total_errors() == 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: testbench/rv_exec_core_assertions.sv
`timescale 1ns/1ns

module rv_exec_core_assertions (
  input logic clk,
  input logic rst_n,
  input logic instr_valid,
  input logic [31:0] instr,
  input logic wb_valid,
  input logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd
);

  localparam int wb_latency = 2;

  int fail_count = 0;
  logic retires;

  // legal encoding that writes a register other than x0
  always_comb begin
    retires = 1'b0;
    case (instr[6:0])
      7'b0110011: begin
        retires = (instr[31:25] == 7'b0000000) ||
                  ((instr[31:25] == 7'b0100000) &&
                   ((instr[14:12] == 3'd0) || (instr[14:12] == 3'd5))) ||
                  ((instr[31:25] == 7'b0000001) && !instr[14]);
      end
      7'b0010011: begin
        // only the shift immediates constrain the upper bits
        retires = (instr[13:12] != 2'b01) || (instr[31:25] == 7'b0000000) ||
                  (instr[14] && (instr[31:25] == 7'b0100000));
      end
      default: retires = 1'b0;
    endcase
    retires = retires && instr_valid && (instr[11:7] != 5'd0);
  end

  quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_valid)
    else begin
      $error("wb_valid is high while reset is asserted");
      fail_count++;
    end

  retire_on_time: assert property (@(posedge clk) disable iff (!rst_n)
    retires |-> ##wb_latency (wb_valid && (wb_rd == $past(instr[11:7], wb_latency))))
    else begin
      $error("strobed instruction did not retire on time with its rd");
      fail_count++;
    end

  no_spurious_wb: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> $past(retires, wb_latency))
    else begin
      $error("wb_valid without a retiring instruction two cycles earlier");
      fail_count++;
    end

endmodule

bind rv_exec_core rv_exec_core_assertions chk0 (
  .clk         (clk),
  .rst_n       (rst_n),
  .instr_valid (instr_valid),
  .instr       (instr),
  .wb_valid    (wb_valid),
  .wb_rd       (wb_rd)
);

// File: hw/rv_exec_core.sv
`timescale 1ns/1ns

module rv_exec_core (
  input  logic clk,
  input  logic rst_n,
  input  logic instr_valid,
  input  logic [31:0] instr,
  output logic wb_valid,
  output logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_isa_pkg::xlen-1:0] wb_data
);

  logic [rv_isa_pkg::reg_addr_w-1:0] rs1;
  logic [rv_isa_pkg::reg_addr_w-1:0] rs2;
  logic [rv_isa_pkg::xlen-1:0] rs1_data;
  logic [rv_isa_pkg::xlen-1:0] rs2_data;
  logic [rv_isa_pkg::xlen-1:0] alu_result;
  logic [rv_isa_pkg::xlen-1:0] mul_result;

  exec_if ex ();

  regfile regfile_u (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wb_valid),
    .wr_rd    (wb_rd),
    .wr_data  (wb_data)
  );

  issue_decode issue_decode_u (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .ex          (ex)
  );

  int_alu int_alu_u (
    .ex         (ex),
    .alu_result (alu_result)
  );

  mul_unit mul_unit_u (
    .ex         (ex),
    .mul_result (mul_result)
  );

  result_merge result_merge_u (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex         (ex),
    .alu_result (alu_result),
    .mul_result (mul_result),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

endmodule

// File: hw/result_merge.sv
`timescale 1ns/1ns

module result_merge (
  input  logic clk,
  input  logic rst_n,
  exec_if.merge ex,
  input  logic [rv_isa_pkg::xlen-1:0] alu_result,
  input  logic [rv_isa_pkg::xlen-1:0] mul_result,
  output logic wb_valid,
  output logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_isa_pkg::xlen-1:0] wb_data
);
  import rv_isa_pkg::*;

  logic [xlen-1:0] unit_result;

  assign unit_result = ex.use_mul ? mul_result : alu_result;

  // x0 never reaches the writeback bus
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex.valid && (ex.rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (ex.valid) begin
      wb_rd <= ex.rd;
      wb_data <= unit_result;
    end
  end

endmodule

// File: hw/mul_unit.sv
`timescale 1ns/1ns

module mul_unit (
  exec_if.unit ex,
  output logic [rv_isa_pkg::xlen-1:0] mul_result
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic [mul_op_w-1:0] mop;
  logic a_signed;
  logic b_signed;
  logic signed [xlen:0] a_ext;
  logic signed [xlen:0] b_ext;
  logic signed [2*xlen+1:0] product;

  assign mop = ex.op[mul_op_w-1:0];
  assign a_signed = (mop == mul_hi_ss) || (mop == mul_hi_su);
  assign b_signed = (mop == mul_hi_ss);

  // one extra bit lets a single signed multiplier cover all three variants
  assign a_ext = {a_signed & ex.operand1[xlen-1], ex.operand1};
  assign b_ext = {b_signed & ex.operand2[xlen-1], ex.operand2};
  assign product = a_ext * b_ext;

  assign mul_result = (mop == mul_lo) ? product[xlen-1:0] : product[2*xlen-1:xlen];

endmodule

// File: hw/int_alu.sv
`timescale 1ns/1ns

module int_alu (
  exec_if.unit ex,
  output logic [rv_isa_pkg::xlen-1:0] alu_result
);
  import core_pkg::*;

  logic [4:0] shamt;

  assign shamt = ex.operand2[4:0];

  always_comb begin
    case (ex.op)
      alu_add:  alu_result = ex.operand1 + ex.operand2;
      alu_sub:  alu_result = ex.operand1 - ex.operand2;
      alu_and:  alu_result = ex.operand1 & ex.operand2;
      alu_or:   alu_result = ex.operand1 | ex.operand2;
      alu_xor:  alu_result = ex.operand1 ^ ex.operand2;
      alu_slt: begin
        alu_result = '0;
        alu_result[0] = $signed(ex.operand1) < $signed(ex.operand2);
      end
      alu_sltu: begin
        alu_result = '0;
        alu_result[0] = ex.operand1 < ex.operand2;
      end
      alu_sll:  alu_result = ex.operand1 << shamt;
      alu_srl:  alu_result = ex.operand1 >> shamt;
      alu_sra:  alu_result = $signed(ex.operand1) >>> shamt;
      default:  alu_result = '0;
    endcase
  end

endmodule

// File: hw/issue_decode.sv
`timescale 1ns/1ns

module issue_decode (
  input  logic clk,
  input  logic rst_n,
  input  logic instr_valid,
  input  rv_isa_pkg::rv_instr_t instr,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_isa_pkg::xlen-1:0] rs1_data,
  input  logic [rv_isa_pkg::xlen-1:0] rs2_data,
  input  logic wb_valid,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_isa_pkg::xlen-1:0] wb_data,
  exec_if.issue ex
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic dec_legal;
  logic dec_use_mul;
  logic dec_op2_reg;
  logic [alu_op_w-1:0] dec_op;
  logic [xlen-1:0] dec_imm;

  logic valid_q;
  logic use_mul_q;
  logic op2_reg_q;
  logic [alu_op_w-1:0] op_q;
  logic [reg_addr_w-1:0] rd_q;
  logic [reg_addr_w-1:0] rs1_q;
  logic [reg_addr_w-1:0] rs2_q;
  logic [xlen-1:0] op1_q;
  logic [xlen-1:0] op2_q;

  function automatic logic [alu_op_w-1:0] base_op(input logic [2:0] f3);
    case (f3)
      f3_sll:     return alu_sll;
      f3_slt:     return alu_slt;
      f3_sltu:    return alu_sltu;
      f3_xor:     return alu_xor;
      f3_srl_sra: return alu_srl;
      f3_or:      return alu_or;
      f3_and:     return alu_and;
      default:    return alu_add;
    endcase
  endfunction

  assign rs1 = instr.r_view.rs1;
  assign rs2 = instr.r_view.rs2;

  always_comb begin
    dec_legal = 1'b0;
    dec_use_mul = 1'b0;
    dec_op2_reg = 1'b0;
    dec_op = alu_add;
    dec_imm = {{(xlen-12){instr.i_view.imm12[11]}}, instr.i_view.imm12};
    case (instr.r_view.opcode)
      op_reg: begin
        dec_op2_reg = 1'b1;
        case (instr.r_view.funct7)
          funct7_base: begin
            dec_legal = 1'b1;
            dec_op = base_op(instr.r_view.funct3);
          end
          funct7_alt: begin
            dec_legal = (instr.r_view.funct3 == f3_add_sub) ||
                        (instr.r_view.funct3 == f3_srl_sra);
            dec_op = (instr.r_view.funct3 == f3_add_sub) ? alu_sub : alu_sra;
          end
          funct7_muldiv: begin
            // upper funct3 half is division and is rejected
            dec_legal = !instr.r_view.funct3[2];
            dec_use_mul = 1'b1;
            case (instr.r_view.funct3)
              f3_mulh:   dec_op = {{(alu_op_w-mul_op_w){1'b0}}, mul_hi_ss};
              f3_mulhsu: dec_op = {{(alu_op_w-mul_op_w){1'b0}}, mul_hi_su};
              f3_mulhu:  dec_op = {{(alu_op_w-mul_op_w){1'b0}}, mul_hi_uu};
              default:   dec_op = {{(alu_op_w-mul_op_w){1'b0}}, mul_lo};
            endcase
          end
          default: ;
        endcase
      end
      op_imm: begin
        dec_op = base_op(instr.i_view.funct3);
        case (instr.i_view.funct3)
          f3_sll: begin
            dec_legal = (instr.i_view.imm12[11:5] == funct7_base);
            dec_imm = {{(xlen-5){1'b0}}, instr.i_view.imm12[4:0]};
          end
          f3_srl_sra: begin
            dec_legal = (instr.i_view.imm12[11:5] == funct7_base) ||
                        (instr.i_view.imm12[11:5] == funct7_alt);
            if (instr.i_view.imm12[11:5] == funct7_alt) begin
              dec_op = alu_sra;
            end
            dec_imm = {{(xlen-5){1'b0}}, instr.i_view.imm12[4:0]};
          end
          default: dec_legal = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_valid && dec_legal && (instr.r_view.rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      use_mul_q <= dec_use_mul;
      op2_reg_q <= dec_op2_reg;
      op_q <= dec_op;
      rd_q <= instr.r_view.rd;
      rs1_q <= instr.r_view.rs1;
      rs2_q <= instr.r_view.rs2;
      op1_q <= rs1_data;
      op2_q <= dec_op2_reg ? rs2_data : dec_imm;
    end
  end

  assign ex.valid = valid_q;
  assign ex.use_mul = use_mul_q;
  assign ex.op = op_q;
  assign ex.rd = rd_q;

  // producer one slot ahead is in writeback now
  assign ex.operand1 = (wb_valid && (wb_rd == rs1_q)) ? wb_data : op1_q;
  assign ex.operand2 = (wb_valid && op2_reg_q && (wb_rd == rs2_q)) ? wb_data : op2_q;

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ns

module regfile (
  input  logic clk,
  input  logic rst_n,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_isa_pkg::xlen-1:0] rs1_data,
  output logic [rv_isa_pkg::xlen-1:0] rs2_data,
  input  logic wr_en,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] wr_rd,
  input  logic [rv_isa_pkg::xlen-1:0] wr_data
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic [xlen-1:0] regs [num_regs];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_rd != '0)) begin
      regs[wr_rd] <= wr_data;
    end
  end

  // x0 reads zero, same-cycle write passes straight through
  assign rs1_data = (rs1 == '0) ? '0 :
                    (wr_en && (wr_rd == rs1)) ? wr_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wr_en && (wr_rd == rs2)) ? wr_data : regs[rs2];

endmodule

// File: hw/exec_if.sv
`timescale 1ns/1ns

interface exec_if;
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic valid;
  logic use_mul;
  logic [alu_op_w-1:0] op;
  logic [xlen-1:0] operand1;
  logic [xlen-1:0] operand2;
  logic [reg_addr_w-1:0] rd;

  modport issue (output valid, use_mul, op, operand1, operand2, rd);

  modport unit (input op, operand1, operand2);

  modport merge (input valid, use_mul, rd);

endinterface

// File: hw/core_pkg.sv
package core_pkg;

  localparam int num_regs = 32;

  localparam int alu_op_w = 4;
  localparam logic [alu_op_w-1:0] alu_add = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub = 4'd1;
  localparam logic [alu_op_w-1:0] alu_and = 4'd2;
  localparam logic [alu_op_w-1:0] alu_or = 4'd3;
  localparam logic [alu_op_w-1:0] alu_xor = 4'd4;
  localparam logic [alu_op_w-1:0] alu_slt = 4'd5;
  localparam logic [alu_op_w-1:0] alu_sltu = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sll = 4'd7;
  localparam logic [alu_op_w-1:0] alu_srl = 4'd8;
  localparam logic [alu_op_w-1:0] alu_sra = 4'd9;

  // carried in the low bits of the shared op field
  localparam int mul_op_w = 2;
  localparam logic [mul_op_w-1:0] mul_lo = 2'd0;
  localparam logic [mul_op_w-1:0] mul_hi_ss = 2'd1;
  localparam logic [mul_op_w-1:0] mul_hi_uu = 2'd2;
  localparam logic [mul_op_w-1:0] mul_hi_su = 2'd3;

endpackage

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // accepted major opcodes
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;

  // funct3 of the base integer ops
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct3 of the multiplies
  localparam logic [2:0] f3_mul = 3'b000;
  localparam logic [2:0] f3_mulh = 3'b001;
  localparam logic [2:0] f3_mulhsu = 3'b010;
  localparam logic [2:0] f3_mulhu = 3'b011;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic [11:0] imm12;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } i_view;
  } rv_instr_t;

endpackage
